// File: build.f
src/sram_pkg.sv
src/sram_mem_if.sv
src/axil_sram_ctrl.sv
src/access_delay_timer.sv
src/sram_store.sv
src/axil_sram.sv
sim/tb_axil_sram.sv

// File: run_sim.sh
#!/bin/sh
# build and run the AXI-Lite SRAM testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module tb_axil_sram \
	-f build.f \
	-o sim_axil_sram

# the simulation exits nonzero on a fatal error, the log decides the verdict
./obj_dir/sim_axil_sram > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	echo "run_sim: simulation passed"
	exit 0
else
	echo "run_sim: simulation failed"
	exit 1
fi

// File: sim/sram_golden.txt
# op addr wdata strb exp_rdata exp_resp (hex fields)
# op R read, W write, B read and write in the same cycle; resp 0 okay, 2 slverr
W 00000010 deadbeef f 00000000 0
R 00000010 00000000 0 deadbeef 0
W 00000020 11223344 f 00000000 0
W 00000021 aaaaaaaa 1 00000000 0
R 00000022 00000000 0 112233aa 0
W 00000023 bbbbbbbb 6 00000000 0
R 00000020 00000000 0 11bbbbaa 0
W 00000022 cccccccc 8 00000000 0
R 00000023 00000000 0 ccbbbbaa 0
W 00000000 0badf00d f 00000000 0
R 00000400 00000000 0 00000000 2
W 00000400 ffffffff f 00000000 2
R 00000000 00000000 0 0badf00d 0
W 80000010 12345678 f 00000000 2
R 80000010 00000000 0 00000000 2
R 00000010 00000000 0 deadbeef 0
W 000003fc 5a5a5a5a f 00000000 0
R 000003ff 00000000 0 5a5a5a5a 0
B 00000010 cafef00d f deadbeef 0
R 00000010 00000000 0 cafef00d 0
B 00000020 00000011 1 ccbbbbaa 0
R 00000021 00000000 0 ccbbbb11 0
B 00000420 12121212 f 00000000 2
R 00000020 00000000 0 ccbbbb11 0
W 00000040 00000001 f 00000000 0
W 00000044 00000002 f 00000000 0
W 00000048 00000003 f 00000000 0
R 00000044 00000000 0 00000002 0
W 00000046 ffff0000 c 00000000 0
R 00000040 00000000 0 00000001 0
R 00000044 00000000 0 ffff0002 0
R 00000048 00000000 0 00000003 0
W 0000004c 12345678 f 00000000 0
W 0000004d 000000ee 1 00000000 0
R 0000004e 00000000 0 123456ee 0
B 00000048 99999999 f 00000003 0
R 00000048 00000000 0 99999999 0
R 000003fc 00000000 0 5a5a5a5a 0
R 00000000 00000000 0 0badf00d 0
R 00000010 00000000 0 cafef00d 0

// File: sim/tb_axil_sram.sv
`timescale 1ns/100ps

module tb_axil_sram import sram_pkg::*; ();
	localparam int CLK_PERIOD = 8;
	localparam int TXN_CYCLES = 8 + 2 + 3 + 6; // latency, handshakes, stall, slack

	logic clk;
	logic rst;
	axi_addr_t araddr;
	logic arvalid;
	logic arready;
	axi_data_t rdata;
	axi_resp_t rresp;
	logic rvalid;
	logic rready;
	axi_addr_t awaddr;
	logic awvalid;
	logic awready;
	axi_data_t wdata;
	axi_strb_t wstrb;
	logic wvalid;
	logic wready;
	axi_resp_t bresp;
	logic bvalid;
	logic bready;

	int seed; // back-pressure source
	int n_trans; // B counts twice
	bit loaded;

	// golden entries
	logic [7:0] op_q[$];
	axi_addr_t addr_q[$];
	axi_data_t wdata_q[$];
	axi_strb_t strb_q[$];
	axi_data_t exp_data_q[$];
	axi_resp_t exp_resp_q[$];

	axil_sram i_dut (
		.clk(clk), .rst(rst),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	task automatic stop_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic report_error(input string msg);
		$display("%s", msg);
		stop_run();
	endtask

	task automatic check_data(input string name, input axi_data_t expected, input axi_data_t actual);
		if (actual !== expected) begin
			$display("Mismatch %s expected %h actual %h", name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_resp(input string name, input axi_resp_t expected, input axi_resp_t actual);
		if (actual !== expected) begin
			$display("Mismatch %s expected %b actual %b", name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Mismatch %s expected %b actual %b", name, expected, actual);
			stop_run();
		end
	endtask

	// drop the rest of a comment line
	task automatic skip_line(input int fd);
		int c;
		c = 0;
		while (c != 10 && c != -1)
			c = $fgetc(fd);
	endtask

	task automatic load_golden();
		int fd;
		int n;
		bit at_end;
		logic [7:0] tok;
		axi_addr_t a;
		axi_data_t d;
		axi_strb_t s;
		axi_data_t e;
		axi_resp_t r;
		fd = $fopen("sim/sram_golden.txt", "r");
		if (fd == 0)
			report_error("cannot open golden file sim/sram_golden.txt");
		at_end = 1'b0;
		while (!at_end) begin
			n = $fscanf(fd, "%s", tok);
			if (n != 1)
				at_end = 1'b1;
			else if (tok == "#")
				skip_line(fd);
			else begin
				n = $fscanf(fd, "%h %h %h %h %h", a, d, s, e, r);
				if (n != 5)
					report_error("golden file has a line with missing fields");
				if (tok != "R" && tok != "W" && tok != "B")
					report_error("golden file has an unknown operation");
				op_q.push_back(tok);
				addr_q.push_back(a);
				wdata_q.push_back(d);
				strb_q.push_back(s);
				exp_data_q.push_back(e);
				exp_resp_q.push_back(r);
				n_trans += (tok == "B") ? 2 : 1;
			end
		end
		$fclose(fd);
	endtask

	task automatic to_drive_point();
		@(posedge clk);
		#1; // inputs change just after the edge
	endtask

	// ar already driven, called at a falling edge
	task automatic finish_read(input string name, input axi_data_t exp_data,
			input axi_resp_t exp_resp);
		int stall;
		axi_data_t held_data;
		axi_resp_t held_resp;
		while (!arready) begin
			to_drive_point();
			@(negedge clk);
		end
		to_drive_point(); // address taken on this edge
		arvalid = 1'b0;
		araddr = '0;
		@(negedge clk);
		while (!rvalid) begin
			check_flag({name, " arready while busy"}, 1'b0, arready);
			check_flag({name, " awready while busy"}, 1'b0, awready);
			check_flag({name, " bvalid ahead of rvalid"}, 1'b0, bvalid);
			@(negedge clk);
		end
		held_data = rdata;
		held_resp = rresp;
		stall = $random(seed) & 3;
		repeat (stall) begin
			to_drive_point();
			@(negedge clk);
			check_flag({name, " rvalid held"}, 1'b1, rvalid);
			check_data({name, " rdata held"}, held_data, rdata);
			check_resp({name, " rresp held"}, held_resp, rresp);
			check_flag({name, " arready during stall"}, 1'b0, arready);
		end
		to_drive_point();
		rready = 1'b1;
		@(negedge clk);
		check_flag({name, " rvalid"}, 1'b1, rvalid);
		check_data({name, " rdata"}, exp_data, rdata);
		check_resp({name, " rresp"}, exp_resp, rresp);
		to_drive_point(); // response taken here
		rready = 1'b0;
		@(negedge clk);
		check_flag({name, " rvalid after handshake"}, 1'b0, rvalid); // seen once only
		check_flag({name, " arready after response"}, 1'b1, arready);
	endtask

	// aw and w already driven, called at a falling edge
	task automatic finish_write(input string name, input axi_resp_t exp_resp);
		int stall;
		axi_resp_t held_resp;
		while (!(awready && wready)) begin
			to_drive_point();
			@(negedge clk);
		end
		to_drive_point();
		awvalid = 1'b0;
		wvalid = 1'b0;
		awaddr = '0;
		wdata = '0;
		wstrb = '0;
		@(negedge clk);
		while (!bvalid) begin
			check_flag({name, " awready while busy"}, 1'b0, awready);
			check_flag({name, " arready while busy"}, 1'b0, arready);
			check_flag({name, " stray rvalid"}, 1'b0, rvalid);
			@(negedge clk);
		end
		held_resp = bresp;
		stall = $random(seed) & 3;
		repeat (stall) begin
			to_drive_point();
			@(negedge clk);
			check_flag({name, " bvalid held"}, 1'b1, bvalid);
			check_resp({name, " bresp held"}, held_resp, bresp);
			check_flag({name, " awready during stall"}, 1'b0, awready);
		end
		to_drive_point();
		bready = 1'b1;
		@(negedge clk);
		check_flag({name, " bvalid"}, 1'b1, bvalid);
		check_resp({name, " bresp"}, exp_resp, bresp);
		to_drive_point();
		bready = 1'b0;
		@(negedge clk);
		check_flag({name, " bvalid after handshake"}, 1'b0, bvalid);
		check_flag({name, " awready after response"}, 1'b1, awready);
	endtask

	task automatic run_read(input string name, input axi_addr_t addr,
			input axi_data_t exp_data, input axi_resp_t exp_resp);
		to_drive_point();
		araddr = addr;
		arvalid = 1'b1;
		@(negedge clk);
		finish_read(name, exp_data, exp_resp);
	endtask

	task automatic run_write(input string name, input axi_addr_t addr, input axi_data_t data,
			input axi_strb_t strb, input axi_resp_t exp_resp);
		to_drive_point();
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		@(negedge clk);
		finish_write(name, exp_resp);
	endtask

	// read and write raised together, read must go first
	task automatic run_both(input string name, input axi_addr_t addr, input axi_data_t data,
			input axi_strb_t strb, input axi_data_t exp_data, input axi_resp_t exp_resp);
		to_drive_point();
		araddr = addr;
		arvalid = 1'b1;
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		@(negedge clk);
		check_flag({name, " awready held off by read"}, 1'b0, awready);
		check_flag({name, " wready held off by read"}, 1'b0, wready);
		finish_read({name, " read"}, exp_data, exp_resp); // old contents
		finish_write({name, " write"}, exp_resp);
	endtask

	// watchdog, sized from the golden file
	initial begin
		wait (loaded);
		#((n_trans * TXN_CYCLES + 4) * CLK_PERIOD);
		report_error("watchdog expired, the DUT stopped responding");
	end

	initial begin
		string name;
		int i;
		seed = 32'h26db;
		n_trans = 0;
		clk = 1'b0;
		rst = 1'b0; // held in reset from the start
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		load_golden();
		loaded = 1'b1;
		repeat (2) @(posedge clk);
		#1 rst = 1'b1;
		@(negedge clk);
		check_flag("reset arready", 1'b1, arready);
		check_flag("reset awready", 1'b1, awready);
		check_flag("reset wready", 1'b1, wready);
		check_flag("reset rvalid", 1'b0, rvalid);
		check_flag("reset bvalid", 1'b0, bvalid);
		for (i = 0; i < op_q.size(); i++) begin
			name = $sformatf("txn %0d %s %h", i, op_q[i], addr_q[i]);
			case (op_q[i])
				"R": run_read(name, addr_q[i], exp_data_q[i], exp_resp_q[i]);
				"W": run_write(name, addr_q[i], wdata_q[i], strb_q[i], exp_resp_q[i]);
				default: run_both(name, addr_q[i], wdata_q[i], strb_q[i],
					exp_data_q[i], exp_resp_q[i]);
			endcase
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: src/axil_sram.sv
`timescale 1ns/100ps

module axil_sram import sram_pkg::*; #(
	parameter int DEPTH_LOG2 = 8, // 256 words
	parameter int DELAY_LOG2 = 3 // up to 8 cycles of latency
) (
	input logic clk,
	input logic rst, // sync, low active

	input axi_addr_t araddr,
	input logic arvalid,
	output logic arready,

	output axi_data_t rdata,
	output axi_resp_t rresp,
	output logic rvalid,
	input logic rready,

	input axi_addr_t awaddr,
	input logic awvalid,
	output logic awready,

	input axi_data_t wdata,
	input axi_strb_t wstrb,
	input logic wvalid,
	output logic wready,

	output axi_resp_t bresp,
	output logic bvalid,
	input logic bready
);
	logic start;
	logic done;

	sram_mem_if #(.DEPTH_LOG2(DEPTH_LOG2)) mem_bus ();

	// channel fsm and decode
	axil_sram_ctrl #(.DEPTH_LOG2(DEPTH_LOG2)) i_ctrl (
		.clk(clk), .rst(rst),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.start(start), .done(done),
		.mem(mem_bus.master)
	);

	access_delay_timer #(.DELAY_LOG2(DELAY_LOG2)) i_timer (
		.clk(clk), .rst(rst),
		.start(start),
		.done(done)
	);

	sram_store #(.DEPTH_LOG2(DEPTH_LOG2)) i_store (
		.clk(clk),
		.mem(mem_bus.slave)
	);

endmodule

// File: src/sram_store.sv
`timescale 1ns/100ps

module sram_store import sram_pkg::*; #(
	parameter int DEPTH_LOG2 = 8
) (
	input logic clk,
	sram_mem_if.slave mem
);
	localparam int LANES = $bits(axi_strb_t);

	axi_data_t words [2**DEPTH_LOG2]; // contents undefined until written

	// byte lane merge on write
	always_ff @(posedge clk) begin
		if (mem.en && mem.we) begin
			for (int i = 0; i < LANES; i++) begin
				if (mem.wstrb[i])
					words[mem.idx][8*i +: 8] <= mem.wdata[8*i +: 8];
			end
		end
	end

	// registered read, held until next strobe
	always_ff @(posedge clk) begin
		if (mem.en && !mem.we)
			mem.rdata <= words[mem.idx];
	end

	// a write must touch at least one byte
	a_wstrb_nonzero: assert property (@(posedge clk)
		mem.en && mem.we |-> mem.wstrb != '0);

endmodule

// File: src/access_delay_timer.sv
`timescale 1ns/100ps

module access_delay_timer #(
	parameter int DELAY_LOG2 = 3 // latency of 1 to 2**DELAY_LOG2 cycles
) (
	input logic clk,
	input logic rst, // sync, low active
	input logic start, // one cycle, only while idle
	output logic done // one cycle when count runs out
);
	logic [15:0] lfsr; // free-running random source
	logic [DELAY_LOG2-1:0] cnt;
	logic busy;

	// x^16 + x^14 + x^13 + x^11, maximal length
	always_ff @(posedge clk) begin
		if (!rst)
			lfsr <= 16'hace1; // any nonzero seed
		else
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
	end

	assign done = busy && (cnt == '0);

	always_ff @(posedge clk) begin
		if (!rst) begin
			busy <= 1'b0;
			cnt <= '0;
		end else if (start) begin
			busy <= 1'b1;
			cnt <= lfsr[DELAY_LOG2-1:0]; // low bits pick the delay
		end else if (busy) begin
			if (done)
				busy <= 1'b0; // single done pulse
			else
				cnt <= cnt - 1'b1;
		end
	end

	// controller keeps one access in flight
	a_no_restart: assert property (@(posedge clk) disable iff (!rst)
		start |-> !busy);

endmodule

// File: src/axil_sram_ctrl.sv
`timescale 1ns/100ps

module axil_sram_ctrl import sram_pkg::*; #(
	parameter int DEPTH_LOG2 = 8
) (
	input logic clk,
	input logic rst, // sync, low active

	input axi_addr_t araddr,
	input logic arvalid,
	output logic arready,

	output axi_data_t rdata,
	output axi_resp_t rresp,
	output logic rvalid,
	input logic rready,

	input axi_addr_t awaddr,
	input logic awvalid,
	output logic awready,

	input axi_data_t wdata,
	input axi_strb_t wstrb,
	input logic wvalid,
	output logic wready,

	output axi_resp_t bresp,
	output logic bvalid,
	input logic bready,

	output logic start, // kicks the latency timer
	input logic done, // latency elapsed
	sram_mem_if.master mem
);
	ctrl_state_t state;
	logic rd_acc; // read handshake this cycle
	logic wr_acc; // aw and w handshake this cycle
	logic ar_oor;
	logic aw_oor;
	logic oor_q; // accepted access hit no word

	// any bit above the word index means no such word
	assign ar_oor = |araddr[$bits(axi_addr_t)-1:DEPTH_LOG2+2];
	assign aw_oor = |awaddr[$bits(axi_addr_t)-1:DEPTH_LOG2+2];

	// single slot, so readies only in idle
	assign arready = (state == IDLE);
	// a pending read holds the write back
	assign awready = (state == IDLE) && !arvalid;
	assign wready = (state == IDLE) && !arvalid;

	assign rd_acc = arvalid && arready;
	assign wr_acc = awvalid && awready && wvalid && wready;

	assign start = rd_acc || wr_acc; // timer runs for errors too

	// strobe the array in the accept cycle, suppressed when out of range
	assign mem.en = (rd_acc && !ar_oor) || (wr_acc && !aw_oor);
	assign mem.we = wr_acc;
	assign mem.idx = rd_acc ? araddr[DEPTH_LOG2+1:2] : awaddr[DEPTH_LOG2+1:2]; // bits 1:0 dropped
	assign mem.wdata = wdata;
	assign mem.wstrb = wstrb;

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= IDLE;
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (rd_acc)
						state <= READ_WAIT; // read wins a tie
					else if (wr_acc)
						state <= WRITE_WAIT;
				end
				READ_WAIT: begin
					if (done) begin
						state <= READ_RESP;
						rvalid <= 1'b1; // one cycle after done
					end
				end
				READ_RESP: begin
					if (rready) begin
						state <= IDLE; // readies back next cycle
						rvalid <= 1'b0;
					end
				end
				WRITE_WAIT: begin
					if (done) begin
						state <= WRITE_RESP;
						bvalid <= 1'b1;
					end
				end
				WRITE_RESP: begin
					if (bready) begin
						state <= IDLE;
						bvalid <= 1'b0;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// response payload
	always_ff @(posedge clk) begin
		if (start)
			oor_q <= rd_acc ? ar_oor : aw_oor;
		if (state == READ_WAIT && done) begin
			rdata <= oor_q ? '0 : mem.rdata; // zero for missing word
			rresp <= oor_q ? RESP_SLVERR : RESP_OKAY;
		end
		if (state == WRITE_WAIT && done)
			bresp <= oor_q ? RESP_SLVERR : RESP_OKAY;
	end

	// only one response channel active at a time
	a_resp_exclusive: assert property (@(posedge clk) disable iff (!rst)
		!(rvalid && bvalid));

	// stalled read response keeps its payload
	a_rdata_hold: assert property (@(posedge clk) disable iff (!rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

	// array strobe is a single pulse, fsm leaves idle behind it
	a_mem_pulse: assert property (@(posedge clk) disable iff (!rst)
		mem.en |=> !mem.en && (state == READ_WAIT || state == WRITE_WAIT));

endmodule

// File: src/sram_mem_if.sv
`timescale 1ns/100ps

// array access path, controller to storage
interface sram_mem_if import sram_pkg::*; #(
	parameter int DEPTH_LOG2 = 8
) ();
	logic en; // one pulse per in-range access
	logic we; // high for write, low for read
	logic [DEPTH_LOG2-1:0] idx; // word index
	axi_data_t wdata;
	axi_strb_t wstrb;
	axi_data_t rdata; // held from cycle after a read strobe

	modport master (
		output en, we, idx, wdata, wstrb,
		input rdata
	);

	modport slave (
		input en, we, idx, wdata, wstrb,
		output rdata
	);

endinterface

// File: src/sram_pkg.sv
package sram_pkg;

	// axi-lite bus widths
	typedef logic [31:0] axi_addr_t; // byte address
	typedef logic [31:0] axi_data_t; // one data word
	typedef logic [3:0] axi_strb_t; // byte lane enables
	typedef logic [1:0] axi_resp_t;

	// response codes
	localparam axi_resp_t RESP_OKAY = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10; // used for out of range words

	// controller states
	typedef enum logic [2:0] {
		IDLE, // readies high, waiting for an address
		READ_WAIT, // latency countdown for a read
		READ_RESP, // rvalid up until rready
		WRITE_WAIT, // latency countdown for a write
		WRITE_RESP // bvalid up until bready
	} ctrl_state_t;

endpackage
